// File: flist.f
+incdir+testbench
source/axi_mem_pkg.sv
source/req_queue.sv
source/rd_burst_engine.sv
source/wr_burst_engine.sv
source/phys_mem_map.sv
source/axi_mem_top.sv
testbench/tb_axi_mem.sv

// File: run.sh
#!/bin/sh
# build and run the AXI4 memory slave testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
	--top-module tb_axi_mem -o sim_axi_mem \
	&& ./obj_dir/sim_axi_mem | tee /dev/stderr | grep -qxF '>>> PASS' \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: source/axi_mem_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// shared widths, codes and address map of the AXI4 memory slave
// referenced by scoped name from every RTL file
// ~~~~~~~~~~~~~~~~~~~~

package axi_mem_pkg;

	// bus field types
	typedef logic [31:0] addr_t;   // byte address
	typedef logic [31:0] data_t;   // one data beat
	typedef logic [3:0]  strb_t;   // byte strobes
	typedef logic [3:0]  id_t;     // transaction id
	typedef logic [7:0]  len_t;    // beats minus one, also beat counters
	typedef logic [2:0]  size_t;   // log2 bytes per beat
	typedef logic [1:0]  burst_t;
	typedef logic [1:0]  resp_t;

	// burst types
	localparam burst_t burst_fixed = 2'd0;
	localparam burst_t burst_incr  = 2'd1;
	localparam burst_t burst_wrap  = 2'd2; // accepted, not served

	// responses
	localparam resp_t resp_okay   = 2'd0;
	localparam resp_t resp_slverr = 2'd2;

	// descriptor queues
	localparam int unsigned queue_depth = 4;
	typedef logic [1:0] qptr_t;
	typedef logic [2:0] qcount_t; // 0 .. queue_depth

	// main memory, 4 KiB
	localparam addr_t       mem_base  = 32'h8000_0000;
	localparam int unsigned mem_words = 1024;
	typedef logic [9:0] mem_index_t;

	// clint style timer words
	localparam addr_t mtime_lo_addr = 32'ha000_0048;
	localparam addr_t mtime_hi_addr = 32'ha000_004c;
	typedef logic [63:0] mtime_t;

	// engine FSMs
	typedef enum logic {
		rd_idle,
		rd_beat   // rdata/rlast registered, rvalid high
	} rd_state_t;

	typedef enum logic [1:0] {
		wr_idle,
		wr_data,  // taking W beats
		wr_resp   // holding B until bready
	} wr_state_t;

endpackage

// File: source/axi_mem_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// AXI4 memory slave top, five channels to queues, engines and memory map
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module axi_mem_top (
	input  logic                 clock,
	input  logic                 reset,

	// AR
	input  axi_mem_pkg::addr_t   araddr,
	input  logic                 arvalid,
	output logic                 arready,
	input  axi_mem_pkg::id_t     arid,
	input  axi_mem_pkg::len_t    arlen,
	input  axi_mem_pkg::size_t   arsize,
	input  axi_mem_pkg::burst_t  arburst,

	// R
	output axi_mem_pkg::data_t   rdata,
	output axi_mem_pkg::resp_t   rresp,
	output logic                 rvalid,
	input  logic                 rready,
	output logic                 rlast,
	output axi_mem_pkg::id_t     rid,

	// AW
	input  axi_mem_pkg::addr_t   awaddr,
	input  logic                 awvalid,
	output logic                 awready,
	input  axi_mem_pkg::id_t     awid,
	input  axi_mem_pkg::len_t    awlen,
	input  axi_mem_pkg::size_t   awsize,
	input  axi_mem_pkg::burst_t  awburst,

	// W
	input  axi_mem_pkg::data_t   wdata,
	input  axi_mem_pkg::strb_t   wstrb,
	input  logic                 wvalid,
	output logic                 wready,
	input  logic                 wlast,

	// B
	output axi_mem_pkg::resp_t   bresp,
	output logic                 bvalid,
	input  logic                 bready,
	output axi_mem_pkg::id_t     bid
);

	// read side head descriptor
	logic                ar_not_empty, ar_pop;
	axi_mem_pkg::addr_t  ar_q_addr;
	axi_mem_pkg::id_t    ar_q_id;
	axi_mem_pkg::len_t   ar_q_len;
	axi_mem_pkg::size_t  ar_q_size;
	axi_mem_pkg::burst_t ar_q_burst;

	// write side head descriptor
	logic                aw_not_empty, aw_pop;
	axi_mem_pkg::addr_t  aw_q_addr;
	axi_mem_pkg::id_t    aw_q_id;
	axi_mem_pkg::len_t   aw_q_len;
	axi_mem_pkg::size_t  aw_q_size;
	axi_mem_pkg::burst_t aw_q_burst;

	// memory ports
	axi_mem_pkg::addr_t  rd_addr, wr_addr;
	axi_mem_pkg::data_t  rd_data, wr_data;
	axi_mem_pkg::strb_t  wr_strb;
	logic                wr_en;

	req_queue u_ar_queue (
		.clock(clock), .reset(reset),
		.push(arvalid), .in_addr(araddr), .in_id(arid), .in_len(arlen),
		.in_size(arsize), .in_burst(arburst), .pop(ar_pop),
		.ready(arready), .not_empty(ar_not_empty),
		.q_addr(ar_q_addr), .q_id(ar_q_id), .q_len(ar_q_len),
		.q_size(ar_q_size), .q_burst(ar_q_burst)
	);

	req_queue u_aw_queue (
		.clock(clock), .reset(reset),
		.push(awvalid), .in_addr(awaddr), .in_id(awid), .in_len(awlen),
		.in_size(awsize), .in_burst(awburst), .pop(aw_pop),
		.ready(awready), .not_empty(aw_not_empty),
		.q_addr(aw_q_addr), .q_id(aw_q_id), .q_len(aw_q_len),
		.q_size(aw_q_size), .q_burst(aw_q_burst)
	);

	rd_burst_engine u_rd_engine (
		.clock(clock), .reset(reset),
		.not_empty(ar_not_empty), .q_addr(ar_q_addr), .q_id(ar_q_id),
		.q_len(ar_q_len), .q_size(ar_q_size), .q_burst(ar_q_burst),
		.rready(rready), .rd_data(rd_data),
		.pop(ar_pop), .rd_addr(rd_addr),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rlast(rlast), .rid(rid)
	);

	wr_burst_engine u_wr_engine (
		.clock(clock), .reset(reset),
		.not_empty(aw_not_empty), .q_addr(aw_q_addr), .q_id(aw_q_id),
		.q_len(aw_q_len), .q_size(aw_q_size), .q_burst(aw_q_burst),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wlast(wlast), .bready(bready),
		.pop(aw_pop), .wready(wready), .bresp(bresp), .bvalid(bvalid), .bid(bid),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data), .wr_strb(wr_strb)
	);

	phys_mem_map u_mem_map (
		.clock(clock), .reset(reset),
		.rd_addr(rd_addr), .wr_en(wr_en), .wr_addr(wr_addr),
		.wr_data(wr_data), .wr_strb(wr_strb),
		.rd_data(rd_data)
	);

endmodule

// File: source/phys_mem_map.sv
// ~~~~~~~~~~~~~~~~~~~~
// physical map, 4 KiB main memory plus the mtime counter words
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module phys_mem_map (
	input  logic               clock,
	input  logic               reset,
	input  axi_mem_pkg::addr_t rd_addr,
	input  logic               wr_en,
	input  axi_mem_pkg::addr_t wr_addr,
	input  axi_mem_pkg::data_t wr_data,
	input  axi_mem_pkg::strb_t wr_strb,
	output axi_mem_pkg::data_t rd_data
);

	axi_mem_pkg::data_t mem [axi_mem_pkg::mem_words];
	axi_mem_pkg::mtime_t mtime;

	axi_mem_pkg::addr_t     rd_off, wr_off;   // offsets from mem_base
	axi_mem_pkg::mem_index_t rd_idx, wr_idx;
	logic rd_in_mem, wr_in_mem;
	logic rd_mtime_lo, rd_mtime_hi;

	// decode, byte offset wraps below base so one compare covers both ends
	assign rd_off    = rd_addr - axi_mem_pkg::mem_base;
	assign wr_off    = wr_addr - axi_mem_pkg::mem_base;
	assign rd_in_mem = rd_off < axi_mem_pkg::addr_t'(axi_mem_pkg::mem_words * 4);
	assign wr_in_mem = wr_off < axi_mem_pkg::addr_t'(axi_mem_pkg::mem_words * 4);
	assign rd_idx    = rd_off[11:2]; // low two bits dropped
	assign wr_idx    = wr_off[11:2];

	assign rd_mtime_lo = (rd_addr[31:2] == axi_mem_pkg::mtime_lo_addr[31:2]);
	assign rd_mtime_hi = (rd_addr[31:2] == axi_mem_pkg::mtime_hi_addr[31:2]);

	// read mux
	always_comb begin
		if (rd_in_mem)        rd_data = mem[rd_idx];
		else if (rd_mtime_lo) rd_data = mtime[31:0];
		else if (rd_mtime_hi) rd_data = mtime[63:32];
		else                  rd_data = '0; // unmapped
	end

	// byte lane writes, only inside main memory
	always_ff @(posedge clock) begin
		if (wr_en && wr_in_mem) begin
			for (int b = 0; b < 4; b++) begin
				if (wr_strb[b]) mem[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
			end
		end
	end

	// free-running timer, read only from the bus
	always_ff @(posedge clock) begin
		if (reset) mtime <= '0;
		else       mtime <= mtime + 64'd1;
	end

endmodule

// File: source/rd_burst_engine.sv
// ~~~~~~~~~~~~~~~~~~~~
// read burst engine, pops AR descriptors and drives R beats in order
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module rd_burst_engine (
	input  logic                clock,
	input  logic                reset,
	input  logic                not_empty,
	input  axi_mem_pkg::addr_t  q_addr,
	input  axi_mem_pkg::id_t    q_id,
	input  axi_mem_pkg::len_t   q_len,
	input  axi_mem_pkg::size_t  q_size,
	input  axi_mem_pkg::burst_t q_burst,
	input  logic                rready,
	input  axi_mem_pkg::data_t  rd_data,   // combinational from memory map
	output logic                pop,
	output axi_mem_pkg::addr_t  rd_addr,
	output axi_mem_pkg::data_t  rdata,
	output axi_mem_pkg::resp_t  rresp,
	output logic                rvalid,
	output logic                rlast,
	output axi_mem_pkg::id_t    rid
);

	axi_mem_pkg::rd_state_t state;

	// burst in flight
	axi_mem_pkg::addr_t  cur_addr;
	axi_mem_pkg::len_t   cur_len;
	axi_mem_pkg::size_t  cur_size;
	axi_mem_pkg::burst_t cur_burst;
	axi_mem_pkg::len_t   cnt;      // beat now on R

	logic                take_head; // start a new burst this cycle
	logic                advance;   // next beat of the same burst
	axi_mem_pkg::len_t   next_cnt;
	axi_mem_pkg::burst_t next_burst;
	axi_mem_pkg::data_t  beat_data;

	assign rvalid   = (state == axi_mem_pkg::rd_beat);
	assign rresp    = axi_mem_pkg::resp_okay; // unmapped reads are zero, still okay
	assign pop      = take_head;
	assign next_cnt = cnt + 8'd1;

	always_comb begin
		take_head = 1'b0;
		advance   = 1'b0;
		case (state)
			axi_mem_pkg::rd_idle: take_head = not_empty;
			axi_mem_pkg::rd_beat: begin
				if (rready) begin
					if (rlast) take_head = not_empty; // chain next burst, no bubble
					else       advance   = 1'b1;
				end
			end
			default: take_head = 1'b0;
		endcase
	end

	// beat address generator
	always_comb begin
		if (take_head) begin
			rd_addr    = q_addr; // beat 0 is the base for both fixed and incr
			next_burst = q_burst;
		end else begin
			next_burst = cur_burst;
			if (cur_burst == axi_mem_pkg::burst_fixed) rd_addr = cur_addr;
			else rd_addr = cur_addr + (axi_mem_pkg::addr_t'(next_cnt) << cur_size);
		end
	end

	// wrap and reserved bursts read as zero
	assign beat_data = (next_burst == axi_mem_pkg::burst_fixed ||
	                    next_burst == axi_mem_pkg::burst_incr) ? rd_data : '0;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= axi_mem_pkg::rd_idle;
			cnt   <= '0;
		end else begin
			if (take_head) begin
				state <= axi_mem_pkg::rd_beat;
				cnt   <= '0;
			end else if (advance) begin
				cnt <= next_cnt;
			end else if (rvalid && rready) begin
				state <= axi_mem_pkg::rd_idle; // last beat gone, queue empty
			end
		end
	end

	// payload, loaded on the same edge as the R transfer
	always_ff @(posedge clock) begin
		if (take_head) begin
			cur_addr  <= q_addr;
			cur_len   <= q_len;
			cur_size  <= q_size;
			cur_burst <= q_burst;
			rid       <= q_id;
			rdata     <= beat_data;
			rlast     <= (q_len == '0); // single beat burst
		end else if (advance) begin
			rdata <= beat_data;
			rlast <= (next_cnt == cur_len);
		end
	end

	r_hold: assert property (@(posedge clock) disable iff (reset)
		(rvalid && !rready) |=> ($stable(rdata) && $stable(rlast)))
		else $error("R payload changed under back-pressure");

endmodule

// File: source/req_queue.sv
// ~~~~~~~~~~~~~~~~~~~~
// circular queue of burst descriptors, one per AR and one per AW channel
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module req_queue (
	input  logic                clock,
	input  logic                reset,
	input  logic                push,      // the channel's valid
	input  axi_mem_pkg::addr_t  in_addr,
	input  axi_mem_pkg::id_t    in_id,
	input  axi_mem_pkg::len_t   in_len,
	input  axi_mem_pkg::size_t  in_size,
	input  axi_mem_pkg::burst_t in_burst,
	input  logic                pop,       // engine took the head
	output logic                ready,     // the channel's ready
	output logic                not_empty,
	output axi_mem_pkg::addr_t  q_addr,
	output axi_mem_pkg::id_t    q_id,
	output axi_mem_pkg::len_t   q_len,
	output axi_mem_pkg::size_t  q_size,
	output axi_mem_pkg::burst_t q_burst
);

	// descriptor slots, one array per field
	axi_mem_pkg::addr_t  slot_addr  [axi_mem_pkg::queue_depth];
	axi_mem_pkg::id_t    slot_id    [axi_mem_pkg::queue_depth];
	axi_mem_pkg::len_t   slot_len   [axi_mem_pkg::queue_depth];
	axi_mem_pkg::size_t  slot_size  [axi_mem_pkg::queue_depth];
	axi_mem_pkg::burst_t slot_burst [axi_mem_pkg::queue_depth];

	axi_mem_pkg::qptr_t   head, tail;
	axi_mem_pkg::qcount_t count;
	logic                 take; // handshake on the address channel

	assign ready     = (count != axi_mem_pkg::qcount_t'(axi_mem_pkg::queue_depth));
	assign not_empty = (count != '0);
	assign take      = push && ready;

	// head is always on show
	assign q_addr  = slot_addr[head];
	assign q_id    = slot_id[head];
	assign q_len   = slot_len[head];
	assign q_size  = slot_size[head];
	assign q_burst = slot_burst[head];

	always_ff @(posedge clock) begin
		if (take) begin
			slot_addr[tail]  <= in_addr;
			slot_id[tail]    <= in_id;
			slot_len[tail]   <= in_len;
			slot_size[tail]  <= in_size;
			slot_burst[tail] <= in_burst;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (take) tail <= tail + 2'd1; // wraps at depth 4
			if (pop)  head <= head + 2'd1;
			case ({take, pop})
				2'b10:   count <= count + 3'd1;
				2'b01:   count <= count - 3'd1;
				default: count <= count; // both or neither
			endcase
		end
	end

	// engines only pop what the queue offers
	pop_needs_entry: assert property (@(posedge clock) disable iff (reset) pop |-> not_empty)
		else $error("req_queue popped while empty");

endmodule

// File: source/wr_burst_engine.sv
// ~~~~~~~~~~~~~~~~~~~~
// write burst engine, takes W beats into memory and answers on B
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module wr_burst_engine (
	input  logic                clock,
	input  logic                reset,
	input  logic                not_empty,
	input  axi_mem_pkg::addr_t  q_addr,
	input  axi_mem_pkg::id_t    q_id,
	input  axi_mem_pkg::len_t   q_len,
	input  axi_mem_pkg::size_t  q_size,
	input  axi_mem_pkg::burst_t q_burst,
	input  axi_mem_pkg::data_t  wdata,
	input  axi_mem_pkg::strb_t  wstrb,
	input  logic                wvalid,
	input  logic                wlast,
	input  logic                bready,
	output logic                pop,
	output logic                wready,
	output axi_mem_pkg::resp_t  bresp,
	output logic                bvalid,
	output axi_mem_pkg::id_t    bid,
	output logic                wr_en,
	output axi_mem_pkg::addr_t  wr_addr,
	output axi_mem_pkg::data_t  wr_data,
	output axi_mem_pkg::strb_t  wr_strb
);

	axi_mem_pkg::wr_state_t state;

	axi_mem_pkg::addr_t  cur_addr;
	axi_mem_pkg::len_t   cur_len;
	axi_mem_pkg::size_t  cur_size;
	axi_mem_pkg::burst_t cur_burst;
	axi_mem_pkg::len_t   cnt;       // beat expected next
	logic                err;       // wlast disagreed on an earlier beat

	logic                beat;      // W transfer this cycle
	logic                is_last;   // count says final beat
	logic                mismatch;

	assign wready   = (state == axi_mem_pkg::wr_data);
	assign bvalid   = (state == axi_mem_pkg::wr_resp);
	assign pop      = (state == axi_mem_pkg::wr_idle) && not_empty;
	assign beat     = wready && wvalid;
	assign is_last  = (cnt == cur_len);
	assign mismatch = (wlast != is_last);

	// memory write port, takes effect at the edge of the W transfer
	assign wr_en   = beat && (cur_burst == axi_mem_pkg::burst_fixed ||
	                          cur_burst == axi_mem_pkg::burst_incr); // wrap ignored
	assign wr_data = wdata;
	assign wr_strb = wstrb;
	assign wr_addr = (cur_burst == axi_mem_pkg::burst_fixed) ? cur_addr :
	                 cur_addr + (axi_mem_pkg::addr_t'(cnt) << cur_size);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= axi_mem_pkg::wr_idle;
			cnt   <= '0;
			err   <= 1'b0;
		end else begin
			case (state)
				axi_mem_pkg::wr_idle: begin
					if (pop) begin
						state <= axi_mem_pkg::wr_data;
						cnt   <= '0;
						err   <= 1'b0;
					end
				end
				axi_mem_pkg::wr_data: begin
					if (beat) begin
						if (is_last) state <= axi_mem_pkg::wr_resp; // length rules, not wlast
						else         cnt   <= cnt + 8'd1;
						err <= err | mismatch;
					end
				end
				axi_mem_pkg::wr_resp: begin
					if (bready) state <= axi_mem_pkg::wr_idle;
				end
				default: state <= axi_mem_pkg::wr_idle;
			endcase
		end
	end

	// descriptor and response payload
	always_ff @(posedge clock) begin
		if (pop) begin
			cur_addr  <= q_addr;
			cur_len   <= q_len;
			cur_size  <= q_size;
			cur_burst <= q_burst;
			bid       <= q_id; // echoed on B
		end
		if (beat && is_last) begin
			bresp <= (err || mismatch) ? axi_mem_pkg::resp_slverr : axi_mem_pkg::resp_okay;
		end
	end

	// W and B never overlap within one burst
	w_b_exclusive: assert property (@(posedge clock) disable iff (reset) !(bvalid && wready))
		else $error("bvalid and wready both high");

endmodule

// File: testbench/tb_axi_mem_tests.svh
// ~~~~~~~~~~~~~~~~~~~~
// directed tests, included inside the testbench module
// ~~~~~~~~~~~~~~~~~~~~

// compare one value, report in hex on mismatch
task automatic check_eq(input string sig, input logic [31:0] got, input logic [31:0] exp);
	checks++;
	assert (got === exp) else begin
		$display("[ERROR] %s: got 0x%h, expected 0x%h", sig, got, exp);
		errors++;
	end
endtask

task automatic report_test(input string name, input int err0);
	tests++;
	if (errors == err0) $display("test %s: ok", name);
	else                $display("test %s: %0d errors", name, errors - err0);
endtask

task automatic test_strobe_merge();
	int err0;
	axi_mem_pkg::resp_t br;
	axi_mem_pkg::id_t   bi;
	err0    = errors;
	wbuf[0] = 32'hffff_ffff;
	sbuf[0] = 4'hf;
	do_write(axi_mem_pkg::mem_base, 4'd1, 8'd0, axi_mem_pkg::burst_incr, 0, br, bi);
	wbuf[0] = 32'h1122_3344;
	sbuf[0] = 4'b0101; // bytes 0 and 2 only
	do_write(axi_mem_pkg::mem_base, 4'd1, 8'd0, axi_mem_pkg::burst_incr, 0, br, bi);
	do_read(axi_mem_pkg::mem_base, 4'd6, 8'd0, axi_mem_pkg::burst_incr);
	check_eq("rdata", rbuf[0], 32'hff22_ff44); // bytes 1 and 3 keep the old 0xff
	check_eq("rresp", rrbuf[0], axi_mem_pkg::resp_okay);
	check_eq("rlast", lbuf[0], 1'b1);
	check_eq("rid", ibuf[0], 4'd6);
	report_test("strobe merge", err0);
endtask

task automatic test_incr_round_trip();
	int err0;
	axi_mem_pkg::resp_t br;
	axi_mem_pkg::id_t   bi;
	axi_mem_pkg::data_t exp_data [8];
	err0 = errors;
	for (int i = 0; i < 8; i++) begin
		exp_data[i] = $random(seed);
		wbuf[i]     = exp_data[i];
		sbuf[i]     = 4'hf;
	end
	do_write(axi_mem_pkg::mem_base + 32'h40, 4'd5, 8'd7, axi_mem_pkg::burst_incr, 7, br, bi);
	check_eq("bresp", br, axi_mem_pkg::resp_okay);
	check_eq("bid", bi, 4'd5);
	do_read(axi_mem_pkg::mem_base + 32'h40, 4'd9, 8'd7, axi_mem_pkg::burst_incr);
	for (int i = 0; i < 8; i++) begin
		check_eq("rdata", rbuf[i], exp_data[i]);
		check_eq("rlast", lbuf[i], i == 7); // only the eighth beat
		check_eq("rid", ibuf[i], 4'd9);
		check_eq("rresp", rrbuf[i], axi_mem_pkg::resp_okay);
	end
	report_test("incr round trip", err0);
endtask

task automatic test_fixed_bursts();
	int err0;
	axi_mem_pkg::resp_t br;
	axi_mem_pkg::id_t   bi;
	err0 = errors;
	for (int k = 0; k < 4; k++) begin
		wbuf[k] = {4{8'h10 + 8'(k)}};
		sbuf[k] = 4'b0001 << k; // one lane per beat
	end
	do_write(axi_mem_pkg::mem_base + 32'h20, 4'd2, 8'd3, axi_mem_pkg::burst_fixed, 3, br, bi);
	check_eq("bresp", br, axi_mem_pkg::resp_okay);
	do_read(axi_mem_pkg::mem_base + 32'h20, 4'd4, 8'd2, axi_mem_pkg::burst_fixed);
	for (int i = 0; i < 3; i++) begin
		check_eq("rdata", rbuf[i], 32'h1312_1110); // lane k from beat k
		check_eq("rlast", lbuf[i], i == 2);
	end
	report_test("fixed bursts", err0);
endtask

task automatic test_outstanding_reads();
	int err0;
	axi_mem_pkg::resp_t br;
	axi_mem_pkg::id_t   bi;
	axi_mem_pkg::id_t   ids [3];
	err0   = errors;
	ids[0] = 4'd3;
	ids[1] = 4'd7;
	ids[2] = 4'd12;
	for (int i = 0; i < 3; i++) begin
		wbuf[i] = 32'hc0de_0000 + 32'(ids[i]);
		sbuf[i] = 4'hf;
	end
	do_write(axi_mem_pkg::mem_base + 32'h80, 4'd0, 8'd2, axi_mem_pkg::burst_incr, 2, br, bi);
	rready = 1'b0; // held off while the three requests queue up
	for (int i = 0; i < 3; i++) begin
		send_ar(axi_mem_pkg::mem_base + 32'h80 + 32'(4 * i), ids[i], 8'd0, 3'd2,
			axi_mem_pkg::burst_incr);
	end
	for (int i = 0; i < 3; i++) begin
		recv_r(rbuf[i], rrbuf[i], lbuf[i], ibuf[i]);
		check_eq("rid", ibuf[i], ids[i]);
		check_eq("rdata", rbuf[i], 32'hc0de_0000 + 32'(ids[i]));
		check_eq("rlast", lbuf[i], 1'b1);
	end
	report_test("outstanding reads", err0);
endtask

task automatic test_wlast_mismatch();
	int err0;
	axi_mem_pkg::resp_t br;
	axi_mem_pkg::id_t   bi;
	err0 = errors;
	for (int i = 0; i < 4; i++) begin
		wbuf[i] = 32'h5a5a_0000 + 32'(i);
		sbuf[i] = 4'hf;
	end
	// four beats declared, wlast early on the second
	do_write(axi_mem_pkg::mem_base + 32'h100, 4'd10, 8'd3, axi_mem_pkg::burst_incr, 1, br, bi);
	check_eq("bresp", br, axi_mem_pkg::resp_slverr);
	check_eq("bid", bi, 4'd10);
	report_test("wlast mismatch", err0);
endtask

task automatic test_mtime_unmapped();
	int err0;
	axi_mem_pkg::data_t t0;
	axi_mem_pkg::data_t t1;
	err0 = errors;
	do_read(axi_mem_pkg::mtime_lo_addr, 4'd2, 8'd0, axi_mem_pkg::burst_incr);
	t0 = rbuf[0];
	repeat (10) @(posedge clock);
	#1;
	do_read(axi_mem_pkg::mtime_lo_addr, 4'd2, 8'd0, axi_mem_pkg::burst_incr);
	t1 = rbuf[0];
	checks++;
	assert (t1 - t0 >= 32'd10) else begin
		$display("mtime advanced by only %0d between reads at least 10 cycles apart", t1 - t0);
		errors++;
	end
	do_read(32'h4000_0000, 4'd8, 8'd0, axi_mem_pkg::burst_incr); // unmapped
	check_eq("rdata", rbuf[0], 32'h0);
	check_eq("rresp", rrbuf[0], axi_mem_pkg::resp_okay);
	report_test("mtime and unmapped reads", err0);
endtask

// File: testbench/tb_axi_mem.sv
// ~~~~~~~~~~~~~~~~~~~~
// testbench for the AXI4 memory slave, bus driver tasks and run control
// directed tests come from the included tests header
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_axi_mem;

	localparam int max_cycles = 5000; // 16 reset + six short tests, a few hundred cycles at most

	logic clock = 1'b0;
	logic reset;

	axi_mem_pkg::addr_t  araddr, awaddr;
	axi_mem_pkg::id_t    arid, awid, rid, bid;
	axi_mem_pkg::len_t   arlen, awlen;
	axi_mem_pkg::size_t  arsize, awsize;
	axi_mem_pkg::burst_t arburst, awburst;
	axi_mem_pkg::data_t  rdata, wdata;
	axi_mem_pkg::resp_t  rresp, bresp;
	axi_mem_pkg::strb_t  wstrb;
	logic arvalid, arready, rvalid, rready, rlast;
	logic awvalid, awready, wvalid, wready, wlast, bvalid, bready;

	integer seed = 32'ha7a5;
	int     cycles = 0;
	int     errors = 0;
	int     checks = 0;
	int     tests  = 0;

	// beat buffers shared by the burst helpers
	axi_mem_pkg::data_t wbuf  [256];
	axi_mem_pkg::strb_t sbuf  [256];
	axi_mem_pkg::data_t rbuf  [256];
	axi_mem_pkg::resp_t rrbuf [256];
	logic               lbuf  [256];
	axi_mem_pkg::id_t   ibuf  [256];

	axi_mem_top u_dut (
		.clock(clock), .reset(reset),
		.araddr(araddr), .arvalid(arvalid), .arready(arready), .arid(arid),
		.arlen(arlen), .arsize(arsize), .arburst(arburst),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.rlast(rlast), .rid(rid),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready), .awid(awid),
		.awlen(awlen), .awsize(awsize), .awburst(awburst),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready), .wlast(wlast),
		.bresp(bresp), .bvalid(bvalid), .bready(bready), .bid(bid)
	);

	always #50 clock = ~clock; // 100 ns period

	// watchdog
	always @(posedge clock) begin
		cycles++;
		if (cycles >= max_cycles) begin
			$display("timeout: run stopped after %0d cycles without finishing", cycles);
			$display(">>> FAIL");
			$finish;
		end
	end

	// all tasks enter and leave 1 ns after a rising edge
	task automatic send_ar(input axi_mem_pkg::addr_t addr, input axi_mem_pkg::id_t id,
			input axi_mem_pkg::len_t len, input axi_mem_pkg::size_t size,
			input axi_mem_pkg::burst_t burst);
		araddr  = addr;
		arid    = id;
		arlen   = len;
		arsize  = size;
		arburst = burst;
		arvalid = 1'b1;
		@(negedge clock);
		while (!arready) @(negedge clock); // sampled mid cycle
		@(posedge clock);
		#1;
		arvalid = 1'b0;
	endtask

	task automatic send_aw(input axi_mem_pkg::addr_t addr, input axi_mem_pkg::id_t id,
			input axi_mem_pkg::len_t len, input axi_mem_pkg::size_t size,
			input axi_mem_pkg::burst_t burst);
		awaddr  = addr;
		awid    = id;
		awlen   = len;
		awsize  = size;
		awburst = burst;
		awvalid = 1'b1;
		@(negedge clock);
		while (!awready) @(negedge clock);
		@(posedge clock);
		#1;
		awvalid = 1'b0;
	endtask

	task automatic send_w(input axi_mem_pkg::data_t data, input axi_mem_pkg::strb_t strb,
			input logic last);
		wdata  = data;
		wstrb  = strb;
		wlast  = last;
		wvalid = 1'b1;
		@(negedge clock);
		while (!wready) @(negedge clock);
		@(posedge clock);
		#1;
		wvalid = 1'b0;
		wlast  = 1'b0;
	endtask

	task automatic recv_r(output axi_mem_pkg::data_t data, output axi_mem_pkg::resp_t resp,
			output logic last, output axi_mem_pkg::id_t id);
		logic done;
		done = 1'b0;
		while (!done) begin
			rready = (($random(seed) & 3) != 0); // roughly one cycle in four held off
			@(negedge clock);
			if (rvalid && rready) begin
				data = rdata;
				resp = rresp;
				last = rlast;
				id   = rid;
				done = 1'b1;
			end
			@(posedge clock);
			#1;
		end
		rready = 1'b0;
	endtask

	task automatic recv_b(output axi_mem_pkg::resp_t resp, output axi_mem_pkg::id_t id);
		logic done;
		done = 1'b0;
		while (!done) begin
			bready = (($random(seed) & 3) != 0);
			@(negedge clock);
			if (bvalid && bready) begin
				resp = bresp;
				id   = bid;
				done = 1'b1;
			end
			@(posedge clock);
			#1;
		end
		bready = 1'b0;
	endtask

	// AW, then wbuf/sbuf beats, then B; wlast goes on beat last_beat
	task automatic do_write(input axi_mem_pkg::addr_t addr, input axi_mem_pkg::id_t id,
			input axi_mem_pkg::len_t len, input axi_mem_pkg::burst_t burst,
			input int last_beat, output axi_mem_pkg::resp_t resp,
			output axi_mem_pkg::id_t id_back);
		send_aw(addr, id, len, 3'd2, burst);
		for (int i = 0; i <= int'(len); i++) begin
			send_w(wbuf[i], sbuf[i], i == last_beat);
		end
		recv_b(resp, id_back);
	endtask

	// AR, then len+1 beats into the read buffers
	task automatic do_read(input axi_mem_pkg::addr_t addr, input axi_mem_pkg::id_t id,
			input axi_mem_pkg::len_t len, input axi_mem_pkg::burst_t burst);
		send_ar(addr, id, len, 3'd2, burst);
		for (int i = 0; i <= int'(len); i++) begin
			recv_r(rbuf[i], rrbuf[i], lbuf[i], ibuf[i]);
		end
	endtask

	`include "tb_axi_mem_tests.svh"

	initial begin
		reset   = 1'b1;
		araddr  = '0;
		arid    = '0;
		arlen   = '0;
		arsize  = '0;
		arburst = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		awaddr  = '0;
		awid    = '0;
		awlen   = '0;
		awsize  = '0;
		awburst = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		wlast   = 1'b0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		repeat (16) @(posedge clock);
		#1;
		reset = 1'b0;

		test_strobe_merge();
		test_incr_round_trip();
		test_fixed_bursts();
		test_outstanding_reads();
		test_wlast_mismatch();
		test_mtime_unmapped();

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule
